// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    localparam int WORD_W    = 32;
    localparam int PC_W      = 32;
    localparam int REG_IDX_W = 5;
    localparam int ALU_OP_W  = 4;

    typedef logic [WORD_W-1:0]    word_t;    // Operands, results, memory data
    typedef logic [PC_W-1:0]      pc_t;      // Program counter and branch targets
    typedef logic [REG_IDX_W-1:0] reg_idx_t; // Register file index
    typedef logic [ALU_OP_W-1:0]  alu_op_t;  // ALU operation code

    // ALU operation codes with shift amounts from operand B[4:0]
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_NOR  = 4'd5;
    localparam alu_op_t ALU_SLT  = 4'd6;  // Signed compare
    localparam alu_op_t ALU_SLTU = 4'd7;  // Unsigned compare
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    localparam alu_op_t ALU_LUI  = 4'd11; // Operand B low half to upper half

    localparam reg_idx_t LINK_REG = 5'd31; // Return address register

endpackage

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
    input  logic               i_clock,
    input  logic               i_arst_n,
    input  logic               i_reg_write,
    input  logic               i_mem_to_reg,
    input  logic               i_mem_read,
    input  logic               i_mem_write,
    input  logic               i_word_en,
    input  logic               i_halfword_en,
    input  logic               i_byte_en,
    input  logic               i_load_unsigned,
    input  logic               i_branch,
    input  logic               i_alu_src,       // Immediate as operand B
    input  logic               i_r31_ctrl,
    input  mips_pkg::alu_op_t  i_alu_op,
    input  mips_pkg::word_t    i_data_a,
    input  mips_pkg::word_t    i_data_b,
    input  mips_pkg::word_t    i_imm,           // Sign-extended immediate
    input  mips_pkg::reg_idx_t i_dest_reg,
    input  mips_pkg::pc_t      i_pc,
    output mips_pkg::word_t    o_alu_result,
    output mips_pkg::word_t    o_store_data,
    output logic               o_zero,
    output mips_pkg::pc_t      o_branch_addr,
    output logic               o_reg_write,
    output logic               o_mem_to_reg,
    output logic               o_mem_read,
    output logic               o_mem_write,
    output logic               o_word_en,
    output logic               o_halfword_en,
    output logic               o_byte_en,
    output logic               o_load_unsigned,
    output logic               o_branch,
    output logic               o_r31_ctrl,
    output mips_pkg::reg_idx_t o_dest_reg,
    output mips_pkg::pc_t      o_pc
);

    mips_pkg::word_t operand_b;
    mips_pkg::word_t alu_result;
    mips_pkg::pc_t   branch_target;
    logic [4:0]      shamt;

    assign operand_b     = i_alu_src ? i_imm : i_data_b;
    assign shamt         = operand_b[4:0];
    assign branch_target = i_pc + 32'd4 + {i_imm[29:0], 2'b00}; // PC+4 plus word offset

    always_comb begin
        case (i_alu_op)
            mips_pkg::ALU_ADD:  alu_result = i_data_a + operand_b;
            mips_pkg::ALU_SUB:  alu_result = i_data_a - operand_b;
            mips_pkg::ALU_AND:  alu_result = i_data_a & operand_b;
            mips_pkg::ALU_OR:   alu_result = i_data_a | operand_b;
            mips_pkg::ALU_XOR:  alu_result = i_data_a ^ operand_b;
            mips_pkg::ALU_NOR:  alu_result = ~(i_data_a | operand_b);
            mips_pkg::ALU_SLT:  alu_result = {31'd0, $signed(i_data_a) < $signed(operand_b)};
            mips_pkg::ALU_SLTU: alu_result = {31'd0, i_data_a < operand_b};
            mips_pkg::ALU_SLL:  alu_result = i_data_a << shamt;
            mips_pkg::ALU_SRL:  alu_result = i_data_a >> shamt;
            mips_pkg::ALU_SRA:  alu_result = $signed(i_data_a) >>> shamt;
            mips_pkg::ALU_LUI:  alu_result = {operand_b[15:0], 16'd0};
            default:            alu_result = '0;
        endcase
    end

    // EX/MEM pipeline register
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_alu_result    <= '0;
            o_store_data    <= '0;
            o_zero          <= 1'b0;
            o_branch_addr   <= '0;
            o_reg_write     <= 1'b0;
            o_mem_to_reg    <= 1'b0;
            o_mem_read      <= 1'b0;
            o_mem_write     <= 1'b0;
            o_word_en       <= 1'b0;
            o_halfword_en   <= 1'b0;
            o_byte_en       <= 1'b0;
            o_load_unsigned <= 1'b0;
            o_branch        <= 1'b0;
            o_r31_ctrl      <= 1'b0;
            o_dest_reg      <= '0;
            o_pc            <= '0;
        end else begin
            o_alu_result    <= alu_result;
            o_store_data    <= i_data_b;           // Store data is always rt
            o_zero          <= (alu_result == '0);
            o_branch_addr   <= branch_target;
            o_reg_write     <= i_reg_write;
            o_mem_to_reg    <= i_mem_to_reg;
            o_mem_read      <= i_mem_read;
            o_mem_write     <= i_mem_write;
            o_word_en       <= i_word_en;
            o_halfword_en   <= i_halfword_en;
            o_byte_en       <= i_byte_en;
            o_load_unsigned <= i_load_unsigned;
            o_branch        <= i_branch;
            o_r31_ctrl      <= i_r31_ctrl;
            o_dest_reg      <= i_dest_reg;
            o_pc            <= i_pc;
        end
    end

    // Memory lane decoding downstream relies on a single access size
    a_one_size: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_mem_read || i_mem_write) |-> $onehot0({i_word_en, i_halfword_en, i_byte_en}))
        else $error("ex_stage: more than one access size enabled");

endmodule

`default_nettype wire

// ==== data_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_memory #(
    parameter int MEM_DEPTH = 256  // Number of words as a power of two
) (
    input  logic            i_clock,
    input  logic            i_mem_write_flag,
    input  logic            i_mem_read_flag,
    input  logic            i_word_en,
    input  logic            i_halfword_en,
    input  logic            i_byte_en,
    input  mips_pkg::word_t i_address,     // Byte address from the ALU
    input  mips_pkg::word_t i_write_data,
    output mips_pkg::word_t o_read_data
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    mips_pkg::word_t  mem [MEM_DEPTH];
    logic [IDX_W-1:0] word_idx;
    logic [1:0]       byte_sel;
    logic [3:0]       lane_en;
    mips_pkg::word_t  lane_data;
    mips_pkg::word_t  rd_shifted;

    assign word_idx   = i_address[IDX_W+1:2];             // Wraps modulo MEM_DEPTH
    assign byte_sel   = i_address[1:0];
    assign rd_shifted = mem[word_idx] >> {byte_sel, 3'b000}; // Addressed lane to bit 0

    // Replicate the low bytes so each enabled lane sees its own copy
    always_comb begin
        lane_en   = 4'b0000;
        lane_data = i_write_data;
        if (i_byte_en) begin
            lane_en   = 4'b0001 << byte_sel;
            lane_data = {4{i_write_data[7:0]}};
        end else if (i_halfword_en) begin
            lane_en   = byte_sel[1] ? 4'b1100 : 4'b0011;
            lane_data = {2{i_write_data[15:0]}};
        end else if (i_word_en) begin
            lane_en = 4'b1111;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_mem_write_flag) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (lane_en[lane]) begin
                    mem[word_idx][8*lane +: 8] <= lane_data[8*lane +: 8];
                end
            end
        end
    end

    always_comb begin
        o_read_data = '0;                      // Idle when no load
        if (i_mem_read_flag) begin
            if (i_byte_en) begin
                o_read_data = {24'd0, rd_shifted[7:0]};
            end else if (i_halfword_en) begin
                o_read_data = {16'd0, rd_shifted[15:0]};
            end else if (i_word_en) begin
                o_read_data = rd_shifted;
            end
        end
    end

    a_aligned: assert property (@(posedge i_clock)
        (i_mem_read_flag || i_mem_write_flag) |->
            !(i_halfword_en && i_address[0]) && !(i_word_en && (i_address[1:0] != 2'b00)))
        else $error("data_memory: misaligned access at %h", i_address);

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage #(
    parameter int MEM_DEPTH = 256
) (
    input  logic               i_clock,
    input  logic               i_arst_n,
    input  mips_pkg::word_t    i_alu_result,    // Also the memory address
    input  mips_pkg::word_t    i_store_data,
    input  logic               i_zero,
    input  mips_pkg::pc_t      i_branch_addr,
    input  logic               i_reg_write,
    input  logic               i_mem_to_reg,
    input  logic               i_mem_read,
    input  logic               i_mem_write,
    input  logic               i_word_en,
    input  logic               i_halfword_en,
    input  logic               i_byte_en,
    input  logic               i_load_unsigned,
    input  logic               i_branch,
    input  logic               i_r31_ctrl,
    input  mips_pkg::reg_idx_t i_dest_reg,
    input  mips_pkg::pc_t      i_pc,
    output logic               o_branch_taken,
    output mips_pkg::pc_t      o_branch_addr,
    output mips_pkg::word_t    o_mem_data,
    output mips_pkg::word_t    o_alu_result,
    output mips_pkg::reg_idx_t o_dest_reg,
    output logic               o_reg_write,
    output logic               o_mem_to_reg,
    output logic               o_r31_ctrl,
    output logic               o_halfword_en,
    output logic               o_byte_en,
    output logic               o_load_unsigned,
    output mips_pkg::pc_t      o_pc
);

    mips_pkg::word_t rd_data;

    data_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_data_memory (
        .i_clock          (i_clock),
        .i_mem_write_flag (i_mem_write),
        .i_mem_read_flag  (i_mem_read),
        .i_word_en        (i_word_en),
        .i_halfword_en    (i_halfword_en),
        .i_byte_en        (i_byte_en),
        .i_address        (i_alu_result),
        .i_write_data     (i_store_data),
        .o_read_data      (rd_data)
    );

    assign o_branch_taken = i_branch & i_zero;  // Equal operands on SUB
    assign o_branch_addr  = i_branch_addr;

    // MEM/WB pipeline register
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mem_data      <= '0;
            o_alu_result    <= '0;
            o_dest_reg      <= '0;
            o_reg_write     <= 1'b0;
            o_mem_to_reg    <= 1'b0;
            o_r31_ctrl      <= 1'b0;
            o_halfword_en   <= 1'b0;
            o_byte_en       <= 1'b0;
            o_load_unsigned <= 1'b0;
            o_pc            <= '0;
        end else begin
            o_mem_data      <= rd_data;
            o_alu_result    <= i_alu_result;
            o_dest_reg      <= i_dest_reg;
            o_reg_write     <= i_reg_write;
            o_mem_to_reg    <= i_mem_to_reg;
            o_r31_ctrl      <= i_r31_ctrl;
            o_halfword_en   <= i_halfword_en; // Size flags drive the load extension
            o_byte_en       <= i_byte_en;
            o_load_unsigned <= i_load_unsigned;
            o_pc            <= i_pc;
        end
    end

endmodule

`default_nettype wire

// ==== wb_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_stage (
    input  mips_pkg::word_t    i_mem_data,      // Lane already at bit 0
    input  mips_pkg::word_t    i_alu_result,
    input  mips_pkg::reg_idx_t i_dest_reg,
    input  logic               i_reg_write,
    input  logic               i_mem_to_reg,
    input  logic               i_r31_ctrl,
    input  logic               i_halfword_en,
    input  logic               i_byte_en,
    input  logic               i_load_unsigned,
    input  mips_pkg::pc_t      i_pc,
    output logic               o_wb_reg_write,
    output mips_pkg::reg_idx_t o_wb_dest_reg,
    output mips_pkg::word_t    o_wb_data
);

    mips_pkg::word_t load_ext;
    mips_pkg::pc_t   link_addr;

    assign link_addr = i_pc + 32'd8; // Skips the delay slot

    always_comb begin
        if (i_byte_en) begin
            load_ext = i_load_unsigned ? {24'd0, i_mem_data[7:0]}
                                       : {{24{i_mem_data[7]}}, i_mem_data[7:0]};
        end else if (i_halfword_en) begin
            load_ext = i_load_unsigned ? {16'd0, i_mem_data[15:0]}
                                       : {{16{i_mem_data[15]}}, i_mem_data[15:0]};
        end else begin
            load_ext = i_mem_data;
        end
    end

    always_comb begin
        if (i_r31_ctrl) begin
            o_wb_data = link_addr;
        end else if (i_mem_to_reg) begin
            o_wb_data = load_ext;
        end else begin
            o_wb_data = i_alu_result;
        end
    end

    // A link always writes its return address
    assign o_wb_reg_write = i_reg_write | i_r31_ctrl;
    assign o_wb_dest_reg  = i_r31_ctrl ? mips_pkg::LINK_REG : i_dest_reg;

endmodule

`default_nettype wire

// ==== mips_back_end.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_back_end #(
    parameter int MEM_DEPTH = 256
) (
    input  logic               i_clock,
    input  logic               i_arst_n,
    input  logic               i_reg_write,
    input  logic               i_mem_to_reg,
    input  logic               i_mem_read,
    input  logic               i_mem_write,
    input  logic               i_word_en,
    input  logic               i_halfword_en,
    input  logic               i_byte_en,
    input  logic               i_load_unsigned,
    input  logic               i_branch,
    input  logic               i_alu_src,
    input  logic               i_r31_ctrl,
    input  mips_pkg::alu_op_t  i_alu_op,
    input  mips_pkg::word_t    i_data_a,
    input  mips_pkg::word_t    i_data_b,
    input  mips_pkg::word_t    i_imm,
    input  mips_pkg::reg_idx_t i_dest_reg,
    input  mips_pkg::pc_t      i_pc,
    output logic               o_branch_taken,  // One cycle after issue
    output mips_pkg::pc_t      o_branch_addr,
    output logic               o_wb_reg_write,  // Two cycles after issue
    output mips_pkg::reg_idx_t o_wb_dest_reg,
    output mips_pkg::word_t    o_wb_data
);

    // EX/MEM fields
    mips_pkg::word_t    ex_alu_result;
    mips_pkg::word_t    ex_store_data;
    logic               ex_zero;
    mips_pkg::pc_t      ex_branch_addr;
    logic               ex_reg_write;
    logic               ex_mem_to_reg;
    logic               ex_mem_read;
    logic               ex_mem_write;
    logic               ex_word_en;
    logic               ex_halfword_en;
    logic               ex_byte_en;
    logic               ex_load_unsigned;
    logic               ex_branch;
    logic               ex_r31_ctrl;
    mips_pkg::reg_idx_t ex_dest_reg;
    mips_pkg::pc_t      ex_pc;

    // MEM/WB fields
    mips_pkg::word_t    mw_mem_data;
    mips_pkg::word_t    mw_alu_result;
    mips_pkg::reg_idx_t mw_dest_reg;
    logic               mw_reg_write;
    logic               mw_mem_to_reg;
    logic               mw_r31_ctrl;
    logic               mw_halfword_en;
    logic               mw_byte_en;
    logic               mw_load_unsigned;
    mips_pkg::pc_t      mw_pc;

    ex_stage u_ex_stage (
        .i_clock (i_clock), .i_arst_n (i_arst_n),
        .i_reg_write (i_reg_write), .i_mem_to_reg (i_mem_to_reg),
        .i_mem_read (i_mem_read), .i_mem_write (i_mem_write),
        .i_word_en (i_word_en), .i_halfword_en (i_halfword_en),
        .i_byte_en (i_byte_en), .i_load_unsigned (i_load_unsigned),
        .i_branch (i_branch), .i_alu_src (i_alu_src),
        .i_r31_ctrl (i_r31_ctrl), .i_alu_op (i_alu_op),
        .i_data_a (i_data_a), .i_data_b (i_data_b),
        .i_imm (i_imm), .i_dest_reg (i_dest_reg), .i_pc (i_pc),
        .o_alu_result (ex_alu_result), .o_store_data (ex_store_data),
        .o_zero (ex_zero), .o_branch_addr (ex_branch_addr),
        .o_reg_write (ex_reg_write), .o_mem_to_reg (ex_mem_to_reg),
        .o_mem_read (ex_mem_read), .o_mem_write (ex_mem_write),
        .o_word_en (ex_word_en), .o_halfword_en (ex_halfword_en),
        .o_byte_en (ex_byte_en), .o_load_unsigned (ex_load_unsigned),
        .o_branch (ex_branch), .o_r31_ctrl (ex_r31_ctrl),
        .o_dest_reg (ex_dest_reg), .o_pc (ex_pc)
    );

    mem_stage #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_mem_stage (
        .i_clock (i_clock), .i_arst_n (i_arst_n),
        .i_alu_result (ex_alu_result), .i_store_data (ex_store_data),
        .i_zero (ex_zero), .i_branch_addr (ex_branch_addr),
        .i_reg_write (ex_reg_write), .i_mem_to_reg (ex_mem_to_reg),
        .i_mem_read (ex_mem_read), .i_mem_write (ex_mem_write),
        .i_word_en (ex_word_en), .i_halfword_en (ex_halfword_en),
        .i_byte_en (ex_byte_en), .i_load_unsigned (ex_load_unsigned),
        .i_branch (ex_branch), .i_r31_ctrl (ex_r31_ctrl),
        .i_dest_reg (ex_dest_reg), .i_pc (ex_pc),
        .o_branch_taken (o_branch_taken), .o_branch_addr (o_branch_addr),
        .o_mem_data (mw_mem_data), .o_alu_result (mw_alu_result),
        .o_dest_reg (mw_dest_reg), .o_reg_write (mw_reg_write),
        .o_mem_to_reg (mw_mem_to_reg), .o_r31_ctrl (mw_r31_ctrl),
        .o_halfword_en (mw_halfword_en), .o_byte_en (mw_byte_en),
        .o_load_unsigned (mw_load_unsigned), .o_pc (mw_pc)
    );

    wb_stage u_wb_stage (
        .i_mem_data (mw_mem_data), .i_alu_result (mw_alu_result),
        .i_dest_reg (mw_dest_reg), .i_reg_write (mw_reg_write),
        .i_mem_to_reg (mw_mem_to_reg), .i_r31_ctrl (mw_r31_ctrl),
        .i_halfword_en (mw_halfword_en), .i_byte_en (mw_byte_en),
        .i_load_unsigned (mw_load_unsigned), .i_pc (mw_pc),
        .o_wb_reg_write (o_wb_reg_write), .o_wb_dest_reg (o_wb_dest_reg),
        .o_wb_data (o_wb_data)
    );

endmodule

`default_nettype wire

// ==== tb_mips_back_end.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mips_back_end;

    localparam int MEM_WORDS   = 64;
    localparam int SEED        = 60761;
    localparam int NUM_INSTR   = 400;
    localparam int CYCLE_LIMIT = NUM_INSTR + 5 * 10 + 20;

    logic               i_clock;
    logic               i_arst_n;
    logic               i_reg_write;
    logic               i_mem_to_reg;
    logic               i_mem_read;
    logic               i_mem_write;
    logic               i_word_en;
    logic               i_halfword_en;
    logic               i_byte_en;
    logic               i_load_unsigned;
    logic               i_branch;
    logic               i_alu_src;
    logic               i_r31_ctrl;
    mips_pkg::alu_op_t  i_alu_op;
    mips_pkg::word_t    i_data_a;
    mips_pkg::word_t    i_data_b;
    mips_pkg::word_t    i_imm;
    mips_pkg::reg_idx_t i_dest_reg;
    mips_pkg::pc_t      i_pc;
    logic               o_branch_taken;
    mips_pkg::pc_t      o_branch_addr;
    logic               o_wb_reg_write;
    mips_pkg::reg_idx_t o_wb_dest_reg;
    mips_pkg::word_t    o_wb_data;

    mips_pkg::word_t    model_mem [MEM_WORDS];
    mips_pkg::word_t    q_data [$];           // Writeback expected two cycles after issue
    mips_pkg::reg_idx_t q_dest [$];
    logic               q_wr [$];
    logic               exp_br_taken;         // Branch expected one cycle after issue
    mips_pkg::pc_t      exp_br_addr;
    int                 error_count;
    int                 tests_passed;
    int                 tests_failed;
    int                 cycle_count;

    mips_back_end #(.MEM_DEPTH(MEM_WORDS)) i_mips_back_end (.*);

    always #50 i_clock = ~i_clock;

    task automatic check_word(input string name, input mips_pkg::word_t got,
                              input mips_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_reg(input string name, input mips_pkg::reg_idx_t got,
                             input mips_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_pc(input string name, input mips_pkg::pc_t got,
                            input mips_pkg::pc_t exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    function automatic mips_pkg::word_t alu_model(input mips_pkg::alu_op_t op,
                                                  input mips_pkg::word_t a,
                                                  input mips_pkg::word_t b);
        logic [4:0]      sh;
        mips_pkg::word_t fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0; // Sign bits shifted in
        case (op)
            mips_pkg::ALU_ADD:  return a + b;
            mips_pkg::ALU_SUB:  return a - b;
            mips_pkg::ALU_AND:  return a & b;
            mips_pkg::ALU_OR:   return a | b;
            mips_pkg::ALU_XOR:  return a ^ b;
            mips_pkg::ALU_NOR:  return ~(a | b);
            mips_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            mips_pkg::ALU_SLTU: return {31'd0, a < b};
            mips_pkg::ALU_SLL:  return a << sh;
            mips_pkg::ALU_SRL:  return a >> sh;
            mips_pkg::ALU_SRA:  return (a >> sh) | fill;
            mips_pkg::ALU_LUI:  return b << 16;
            default:            return '0;
        endcase
    endfunction

    function automatic mips_pkg::word_t load_model(input mips_pkg::word_t addr);
        mips_pkg::word_t w;
        logic [7:0]      b;
        logic [15:0]     h;
        w = model_mem[addr[7:2]];           // 64 words wrap on address bits 7..2
        b = w[8*addr[1:0] +: 8];
        h = w[16*addr[1] +: 16];
        if (i_byte_en) begin
            return i_load_unsigned ? {24'd0, b} : {{24{b[7]}}, b};
        end else if (i_halfword_en) begin
            return i_load_unsigned ? {16'd0, h} : {{16{h[15]}}, h};
        end
        return w;
    endfunction

    task automatic store_model(input mips_pkg::word_t addr, input mips_pkg::word_t data);
        if (i_byte_en) begin
            model_mem[addr[7:2]][8*addr[1:0] +: 8] = data[7:0];
        end else if (i_halfword_en) begin
            model_mem[addr[7:2]][16*addr[1] +: 16] = data[15:0];
        end else begin
            model_mem[addr[7:2]] = data;
        end
    endtask

    function automatic mips_pkg::word_t rand_addr(input int size);
        mips_pkg::word_t addr;
        addr = $urandom_range(0, 4 * MEM_WORDS - 1);
        if (size == 1) begin
            addr[0] = 1'b0;
        end else if (size == 2) begin
            addr[1:0] = 2'b00;
        end
        return addr;
    endfunction

    task automatic reset_model();
        q_data.delete();
        q_dest.delete();
        q_wr.delete();
        repeat (2) begin                    // Pipeline holds two empty slots
            q_data.push_back('0);
            q_dest.push_back('0);
            q_wr.push_back(1'b0);
        end
        exp_br_taken = 1'b0;
        exp_br_addr  = '0;
    endtask

    // Expected results for the instruction now on the inputs
    task automatic record_issue();
        mips_pkg::word_t    res;
        mips_pkg::word_t    data;
        mips_pkg::reg_idx_t dest;
        logic               wr;
        res          = alu_model(i_alu_op, i_data_a, i_alu_src ? i_imm : i_data_b);
        data         = res;
        dest         = i_dest_reg;
        wr           = i_reg_write;
        exp_br_taken = i_branch && (res == '0);
        exp_br_addr  = i_pc + 32'd4 + (i_imm << 2);
        if (i_r31_ctrl) begin
            data = i_pc + 32'd8;
            dest = mips_pkg::LINK_REG;
            wr   = 1'b1;
        end else if (i_mem_to_reg) begin
            data = load_model(res);
        end
        if (i_mem_write) begin
            store_model(res, i_data_b);
        end
        q_data.push_back(data);
        q_dest.push_back(dest);
        q_wr.push_back(wr);
    endtask

    task automatic check_pipeline();
        mips_pkg::word_t    e_data;
        mips_pkg::reg_idx_t e_dest;
        logic               e_wr;
        e_data = q_data.pop_front();
        e_dest = q_dest.pop_front();
        e_wr   = q_wr.pop_front();
        check_flag("o_wb_reg_write", o_wb_reg_write, e_wr);
        if (e_wr) begin
            check_reg("o_wb_dest_reg", o_wb_dest_reg, e_dest);
            check_word("o_wb_data", o_wb_data, e_data);
        end
        check_flag("o_branch_taken", o_branch_taken, exp_br_taken);
        if (exp_br_taken) begin
            check_pc("o_branch_addr", o_branch_addr, exp_br_addr);
        end
    endtask

    task automatic next_cycle();
        @(posedge i_clock);
        #1;
        check_pipeline();                   // Outputs settled after the edge
        #4;
    endtask

    task automatic load_bubble();
        i_reg_write     = 1'b0;
        i_mem_to_reg    = 1'b0;
        i_mem_read      = 1'b0;
        i_mem_write     = 1'b0;
        i_word_en       = 1'b0;
        i_halfword_en   = 1'b0;
        i_byte_en       = 1'b0;
        i_load_unsigned = 1'b0;
        i_branch        = 1'b0;
        i_alu_src       = 1'b0;
        i_r31_ctrl      = 1'b0;
        i_alu_op        = mips_pkg::alu_op_t'($urandom_range(0, 11));
        i_data_a        = $urandom;
        i_data_b        = $urandom;
        i_imm           = $urandom;
        i_dest_reg      = mips_pkg::reg_idx_t'($urandom_range(0, 31));
        i_pc            = $urandom & 32'hFFFF_FFFC;
    endtask

    task automatic set_access(input int size, input mips_pkg::word_t addr);
        logic [15:0] off;
        off           = 16'($urandom);
        i_imm         = {{16{off[15]}}, off};
        i_data_a      = addr - i_imm;       // Base plus offset lands on addr
        i_alu_src     = 1'b1;
        i_alu_op      = mips_pkg::ALU_ADD;
        i_byte_en     = (size == 0);
        i_halfword_en = (size == 1);
        i_word_en     = (size == 2);
    endtask

    task automatic issue_bubble();
        next_cycle();
        load_bubble();
        record_issue();
    endtask

    task automatic issue_alu(input mips_pkg::alu_op_t op, input logic use_imm);
        next_cycle();
        load_bubble();
        i_reg_write = 1'b1;
        i_alu_op    = op;
        i_alu_src   = use_imm;
        record_issue();
    endtask

    task automatic issue_store(input int size, input mips_pkg::word_t addr);
        next_cycle();
        load_bubble();
        set_access(size, addr);
        i_mem_write = 1'b1;
        record_issue();
    endtask

    task automatic issue_load(input int size, input logic uns, input mips_pkg::word_t addr);
        next_cycle();
        load_bubble();
        set_access(size, addr);
        i_mem_read      = 1'b1;
        i_mem_to_reg    = 1'b1;
        i_reg_write     = 1'b1;
        i_load_unsigned = uns;
        record_issue();
    endtask

    task automatic issue_branch(input logic equal, input logic flag);
        next_cycle();
        load_bubble();
        i_alu_op = mips_pkg::ALU_SUB;
        i_branch = flag;
        if (equal) begin
            i_data_b = i_data_a;
        end else begin
            i_data_b = i_data_a + 32'd1 + $urandom_range(0, 999);
        end
        record_issue();
    endtask

    task automatic issue_link();
        next_cycle();
        load_bubble();
        i_r31_ctrl  = 1'b1;
        i_reg_write = ($urandom_range(0, 1) == 1);
        record_issue();
    endtask

    task automatic issue_random();
        int kind;
        int size;
        kind = $urandom_range(0, 6);
        size = $urandom_range(0, 2);
        case (kind)
            0: issue_alu(mips_pkg::alu_op_t'($urandom_range(0, 11)), 1'b0);
            1: issue_alu(mips_pkg::alu_op_t'($urandom_range(0, 11)), 1'b1);
            2: issue_load(size, $urandom_range(0, 1) == 1, rand_addr(size));
            3: issue_store(size, rand_addr(size));
            4: issue_branch($urandom_range(0, 1) == 1, 1'b1);
            5: issue_link();
            default: issue_bubble();
        endcase
    endtask

    // Reset lands while a link and a taken branch are in flight
    task automatic pulse_reset();
        issue_link();
        issue_branch(1'b1, 1'b1);
        @(posedge i_clock);
        #5;
        i_arst_n = 1'b0;
        #1;
        check_flag("o_wb_reg_write", o_wb_reg_write, 1'b0);
        check_flag("o_branch_taken", o_branch_taken, 1'b0);
        repeat (3) begin                    // Taken branch stays on the inputs
            @(posedge i_clock);
            #1;
            check_flag("o_wb_reg_write", o_wb_reg_write, 1'b0);
            check_flag("o_branch_taken", o_branch_taken, 1'b0);
        end
        #4;
        load_bubble();
        i_arst_n = 1'b1;
        reset_model();
    endtask

    task automatic finish_test(input int num, input string name, input int errs_before);
        issue_bubble();
        issue_bubble();                     // Drain the last two instructions
        if (error_count == errs_before) begin
            tests_passed++;
            $display("Test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d mismatches", num, name,
                     error_count - errs_before);
        end
    endtask

    initial begin
        int              errs;
        int              st_size;
        int              ld_size;
        mips_pkg::word_t st_addr;
        mips_pkg::word_t ld_addr;
        void'($urandom(SEED));
        i_clock      = 1'b0;
        i_arst_n     = 1'b0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_bubble();
        reset_model();
        repeat (3) @(posedge i_clock);
        #5;
        i_arst_n = 1'b1;

        errs = error_count;
        for (int i = 0; i < 80; i++) begin
            issue_alu(mips_pkg::alu_op_t'(i % 12), (i / 12) % 2 == 1);
        end
        finish_test(1, "ALU operations", errs);

        errs = error_count;
        for (int i = 0; i < MEM_WORDS; i++) begin
            issue_store(2, i * 4);          // Gives every word a known value
        end
        for (int i = 0; i < 28; i++) begin
            st_size = $urandom_range(0, 2);
            ld_size = $urandom_range(0, 2);
            st_addr = rand_addr(st_size);
            ld_addr = (st_addr & 32'hFFFF_FFFC) | (rand_addr(ld_size) & 32'h3);
            issue_store(st_size, st_addr);
            issue_load(ld_size, $urandom_range(0, 1) == 1, ld_addr);
        end
        finish_test(2, "Stores then loads", errs);

        errs = error_count;
        for (int i = 0; i < 60; i++) begin
            issue_branch(i % 3 != 1, i % 3 != 2);
        end
        finish_test(3, "Branches", errs);

        errs = error_count;
        for (int i = 0; i < 40; i++) begin
            issue_link();
        end
        finish_test(4, "Links", errs);

        errs = error_count;
        pulse_reset();
        for (int i = 0; i < 98; i++) begin
            issue_random();
        end
        finish_test(5, "Reset and bubbles", errs);

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge i_clock);
            cycle_count++;
        end
        $display("Timeout: the run was still busy after %0d clock cycles", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
mips_pkg.sv
ex_stage.sv
data_memory.sv
mem_stage.sv
wb_stage.sv
mips_back_end.sv
tb_mips_back_end.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then judge the log
set -u

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

TOP=tb_mips_back_end
LOG=sim.log

verilator --binary --timing -f tb.f --top-module "$TOP" -o "sim_$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed" "$LOG"; then
    echo "Simulation PASS"
    exit 0
else
    echo "Simulation FAIL"
    exit 1
fi
